// ==== verilog/ns_msg_pkg.sv ====
`default_nettype none

package ns_msg_pkg;

	localparam int DATA_W = 16;
	localparam int NODE_FIELD_W = 2;
	localparam int SUB_FIELD_W = 6;
	localparam int DST_W = NODE_FIELD_W + SUB_FIELD_W;

	// destination word, flat address or node/sub fields
	typedef union packed {
		logic [DST_W-1:0] addr;
		struct packed {
			logic [NODE_FIELD_W-1:0] node;
			logic [SUB_FIELD_W-1:0] sub;
		} f;
	} dst_t;

	typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

// ==== verilog/ns_net_pkg.sv ====
`default_nettype none

package ns_net_pkg;

	localparam int NODE_COUNT = 3;
	// local lanes plus the unroutable tail
	localparam int LANE_COUNT = NODE_COUNT + 1;
	localparam int LANE_W = 2;
	localparam int NODE_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// ==== verilog/ns_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module ns_ingress (
	input  wire                i_clk,
	input  wire                reset,
	input  wire                in_valid,
	input  ns_msg_pkg::dst_t   in_dst,
	input  ns_msg_pkg::data_t  in_dat,
	input  wire                net_ready,
	input  wire                snd_ack,
	output logic               in_ready,
	output logic               snd_req,
	output ns_msg_pkg::dst_t   snd_dst,
	output ns_msg_pkg::data_t  snd_dat
);

	// high from a host transfer until ack has fallen again
	logic busy;
	logic take;

	assign take = in_valid && in_ready && !busy;

	always_ff @(posedge i_clk) begin
		if (reset) begin
			busy <= 1'b0;
			snd_req <= 1'b0;
			in_ready <= 1'b0;
		end else if (!busy) begin
			if (take) begin
				busy <= 1'b1;
				snd_req <= 1'b1;
				in_ready <= 1'b0;
			end else begin
				in_ready <= net_ready;
			end
		end else if (snd_req) begin
			// receiver has the message
			if (snd_ack) begin
				snd_req <= 1'b0;
			end
		end else if (!snd_ack) begin
			// four-phase cycle closed
			busy <= 1'b0;
			in_ready <= net_ready;
		end
	end

	// message held stable while busy
	always_ff @(posedge i_clk) begin
		if (take) begin
			snd_dst <= in_dst;
			snd_dat <= in_dat;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/nd_1to2.sv ====
`timescale 1ns/1ps
`default_nettype none

module nd_1to2 #(
	parameter int NODE_IDX = 0
) (
	input  wire                i_clk,
	input  wire                reset,
	output logic               ready,
	input  wire                rcv_req,
	input  ns_msg_pkg::dst_t   rcv_dst,
	input  ns_msg_pkg::data_t  rcv_dat,
	output logic               rcv_ack,
	output logic               snd0_req,
	output ns_msg_pkg::dst_t   snd0_dst,
	output ns_msg_pkg::data_t  snd0_dat,
	input  wire                snd0_ack,
	output logic               snd1_req,
	output ns_msg_pkg::dst_t   snd1_dst,
	output ns_msg_pkg::data_t  snd1_dat,
	input  wire                snd1_ack
);

	logic rdy;
	logic rcv_ack_r;

	// buffer 0 is local, buffer 1 is forward
	ns_msg_pkg::dst_t mem_dst [2][ns_net_pkg::NODE_FIFO_DEPTH];
	ns_msg_pkg::data_t mem_dat [2][ns_net_pkg::NODE_FIFO_DEPTH];
	logic [$clog2(ns_net_pkg::NODE_FIFO_DEPTH)-1:0] wr_ptr [2];
	logic [$clog2(ns_net_pkg::NODE_FIFO_DEPTH)-1:0] rd_ptr [2];
	logic [$clog2(ns_net_pkg::NODE_FIFO_DEPTH+1)-1:0] cnt [2];

	// output registers per buffer
	logic [1:0] out_req;
	ns_msg_pkg::dst_t out_dst [2];
	ns_msg_pkg::data_t out_dat [2];

	logic [1:0] snd_ack_v;
	logic [1:0] push;
	logic [1:0] pop;
	logic [1:0] full;
	logic [1:0] empty;
	logic tgt;

	assign snd_ack_v = {snd1_ack, snd0_ack};

	// claim the message when its node field names this node
	assign tgt = (rcv_dst.f.node != NODE_IDX);

	always_comb begin
		push = 2'b00;
		for (int b = 0; b < 2; b++) begin
			full[b] = (cnt[b] == ns_net_pkg::NODE_FIFO_DEPTH);
			empty[b] = (cnt[b] == 0);
			// refill an output only after its previous handshake is done
			pop[b] = rdy && !empty[b] && !out_req[b] && !snd_ack_v[b];
		end
		// a full target stalls the input
		if (rdy && rcv_req && !rcv_ack_r && !full[tgt]) begin
			push[tgt] = 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (reset) begin
			rdy <= 1'b0;
			rcv_ack_r <= 1'b0;
			out_req <= 2'b00;
			for (int b = 0; b < 2; b++) begin
				wr_ptr[b] <= '0;
				rd_ptr[b] <= '0;
				cnt[b] <= '0;
			end
		end else begin
			// init cycle after reset
			rdy <= 1'b1;
			if (|push) begin
				rcv_ack_r <= 1'b1;
			end else if (!rcv_req && rcv_ack_r) begin
				rcv_ack_r <= 1'b0;
			end
			for (int b = 0; b < 2; b++) begin
				if (push[b]) begin
					wr_ptr[b] <= wr_ptr[b] + 1'b1;
				end
				if (pop[b]) begin
					rd_ptr[b] <= rd_ptr[b] + 1'b1;
					out_req[b] <= 1'b1;
				end else if (out_req[b] && snd_ack_v[b]) begin
					out_req[b] <= 1'b0;
				end
				if (push[b] && !pop[b]) begin
					cnt[b] <= cnt[b] + 1'b1;
				end else if (pop[b] && !push[b]) begin
					cnt[b] <= cnt[b] - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (|push) begin
			mem_dst[tgt][wr_ptr[tgt]] <= rcv_dst;
			mem_dat[tgt][wr_ptr[tgt]] <= rcv_dat;
		end
		for (int b = 0; b < 2; b++) begin
			if (pop[b]) begin
				out_dst[b] <= mem_dst[b][rd_ptr[b]];
				out_dat[b] <= mem_dat[b][rd_ptr[b]];
			end
		end
	end

	assign ready = rdy;
	assign rcv_ack = rcv_ack_r;

	assign snd0_req = out_req[0];
	assign snd0_dst = out_dst[0];
	assign snd0_dat = out_dat[0];

	assign snd1_req = out_req[1];
	assign snd1_dst = out_dst[1];
	assign snd1_dat = out_dat[1];

endmodule

`default_nettype wire

// ==== verilog/ns_egress_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ns_egress_arbiter (
	input  wire                                                i_clk,
	input  wire                                                reset,
	input  wire [ns_net_pkg::LANE_COUNT-1:0]                   lane_req,
	input  ns_msg_pkg::dst_t [ns_net_pkg::LANE_COUNT-1:0]      lane_dst,
	input  ns_msg_pkg::data_t [ns_net_pkg::LANE_COUNT-1:0]     lane_dat,
	output logic [ns_net_pkg::LANE_COUNT-1:0]                  lane_ack,
	input  wire                                                out_ready,
	output logic                                               out_valid,
	output ns_msg_pkg::dst_t                                   out_dst,
	output ns_msg_pkg::data_t                                  out_dat,
	output logic [ns_net_pkg::LANE_W-1:0]                      out_lane,
	output logic [ns_msg_pkg::SUB_FIELD_W-1:0]                 out_sub
);

	// last granted lane, also the lane being served
	logic [ns_net_pkg::LANE_W-1:0] grant;
	logic [ns_net_pkg::LANE_W-1:0] pick_lane;
	logic pick_found;
	logic idle;
	logic load;

	// free when nothing is presented and no ack is outstanding
	assign idle = !out_valid && !(|lane_ack);
	assign load = idle && pick_found;

	// round-robin search starting after the last grant
	always_comb begin
		logic [31:0] idx;
		pick_found = 1'b0;
		pick_lane = '0;
		for (int i = 1; i <= ns_net_pkg::LANE_COUNT; i++) begin
			idx = (32'(grant) + i) % ns_net_pkg::LANE_COUNT;
			if (!pick_found && lane_req[idx]) begin
				pick_found = 1'b1;
				pick_lane = idx[ns_net_pkg::LANE_W-1:0];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (reset) begin
			grant <= '1;
			out_valid <= 1'b0;
			lane_ack <= '0;
		end else if (load) begin
			grant <= pick_lane;
			out_valid <= 1'b1;
		end else if (out_valid) begin
			// host took it, now close the lane handshake
			if (out_ready) begin
				out_valid <= 1'b0;
				lane_ack[grant] <= 1'b1;
			end
		end else if (!lane_req[grant]) begin
			lane_ack[grant] <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			out_dst <= lane_dst[pick_lane];
			out_dat <= lane_dat[pick_lane];
			out_sub <= lane_dst[pick_lane].f.sub;
		end
	end

	assign out_lane = grant;

endmodule

`default_nettype wire

// ==== verilog/ns_router_net.sv ====
`timescale 1ns/1ps
`default_nettype none

module ns_router_net (
	input  wire                                 i_clk,
	input  wire                                 reset,
	input  wire                                 in_valid,
	input  ns_msg_pkg::dst_t                    in_dst,
	input  ns_msg_pkg::data_t                   in_dat,
	output logic                                in_ready,
	output logic                                net_ready,
	output logic                                out_valid,
	output ns_msg_pkg::dst_t                    out_dst,
	output ns_msg_pkg::data_t                   out_dat,
	output logic [ns_net_pkg::LANE_W-1:0]       out_lane,
	output logic [ns_msg_pkg::SUB_FIELD_W-1:0]  out_sub,
	input  wire                                 out_ready
);

	// chain channels, 0 from the ingress, NODE_COUNT is the tail
	logic [ns_net_pkg::NODE_COUNT:0] chnl_req;
	logic [ns_net_pkg::NODE_COUNT:0] chnl_ack;
	ns_msg_pkg::dst_t [ns_net_pkg::NODE_COUNT:0] chnl_dst;
	ns_msg_pkg::data_t [ns_net_pkg::NODE_COUNT:0] chnl_dat;

	// egress lanes
	logic [ns_net_pkg::LANE_COUNT-1:0] lane_req;
	logic [ns_net_pkg::LANE_COUNT-1:0] lane_ack;
	ns_msg_pkg::dst_t [ns_net_pkg::LANE_COUNT-1:0] lane_dst;
	ns_msg_pkg::data_t [ns_net_pkg::LANE_COUNT-1:0] lane_dat;

	logic [ns_net_pkg::NODE_COUNT-1:0] node_ready;

	assign net_ready = &node_ready;

	ns_ingress ns_ingress_i (
		.i_clk     (i_clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_dst    (in_dst),
		.in_dat    (in_dat),
		.net_ready (net_ready),
		.snd_ack   (chnl_ack[0]),
		.in_ready  (in_ready),
		.snd_req   (chnl_req[0]),
		.snd_dst   (chnl_dst[0]),
		.snd_dat   (chnl_dat[0])
	);

	for (genvar k = 0; k < ns_net_pkg::NODE_COUNT; k++) begin : g_node
		nd_1to2 #(
			.NODE_IDX (k)
		) nd_1to2_i (
			.i_clk    (i_clk),
			.reset    (reset),
			.ready    (node_ready[k]),
			.rcv_req  (chnl_req[k]),
			.rcv_dst  (chnl_dst[k]),
			.rcv_dat  (chnl_dat[k]),
			.rcv_ack  (chnl_ack[k]),
			.snd0_req (lane_req[k]),
			.snd0_dst (lane_dst[k]),
			.snd0_dat (lane_dat[k]),
			.snd0_ack (lane_ack[k]),
			.snd1_req (chnl_req[k+1]),
			.snd1_dst (chnl_dst[k+1]),
			.snd1_dat (chnl_dat[k+1]),
			.snd1_ack (chnl_ack[k+1])
		);
	end

	// unclaimed messages leave the tail as the last lane
	assign lane_req[ns_net_pkg::NODE_COUNT] = chnl_req[ns_net_pkg::NODE_COUNT];
	assign lane_dst[ns_net_pkg::NODE_COUNT] = chnl_dst[ns_net_pkg::NODE_COUNT];
	assign lane_dat[ns_net_pkg::NODE_COUNT] = chnl_dat[ns_net_pkg::NODE_COUNT];
	assign chnl_ack[ns_net_pkg::NODE_COUNT] = lane_ack[ns_net_pkg::NODE_COUNT];

	ns_egress_arbiter ns_egress_arbiter_i (
		.i_clk     (i_clk),
		.reset     (reset),
		.lane_req  (lane_req),
		.lane_dst  (lane_dst),
		.lane_dat  (lane_dat),
		.lane_ack  (lane_ack),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_dst   (out_dst),
		.out_dat   (out_dat),
		.out_lane  (out_lane),
		.out_sub   (out_sub)
	);

endmodule

`default_nettype wire

// ==== dv/ns_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ns_clk_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic i_clk,
	output logic reset
);

	initial begin
		i_clk = 1'b0;
		forever begin
			#(PERIOD / 2);
			i_clk = ~i_clk;
		end
	end

	// release 1 ns after an edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge i_clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== dv/ns_router_net_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ns_router_net_tb;

	localparam int CLK_PERIOD = 100;
	localparam int STREAM_COUNT = 40;
	localparam int FILL_MAX = 48;
	localparam int STALL_CYCLES = 20;
	localparam int MSG_TOTAL = ns_net_pkg::NODE_COUNT + 1 + STREAM_COUNT + FILL_MAX;
	localparam int TIMEOUT_CYCLES = MSG_TOTAL * 60 + 200;

	logic i_clk;
	logic reset;
	logic in_valid;
	ns_msg_pkg::dst_t in_dst;
	ns_msg_pkg::data_t in_dat;
	logic in_ready;
	logic net_ready;
	logic out_valid;
	ns_msg_pkg::dst_t out_dst;
	ns_msg_pkg::data_t out_dat;
	logic [ns_net_pkg::LANE_W-1:0] out_lane;
	logic [ns_msg_pkg::SUB_FIELD_W-1:0] out_sub;
	logic out_ready;

	integer seed;

	// expected messages, one queue per lane
	ns_msg_pkg::dst_t exp_dst [ns_net_pkg::LANE_COUNT][$];
	ns_msg_pkg::data_t exp_dat [ns_net_pkg::LANE_COUNT][$];

	ns_clk_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (3)
	) ns_clk_gen_i (
		.i_clk (i_clk),
		.reset (reset)
	);

	ns_router_net ns_router_net_i (
		.i_clk     (i_clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_dst    (in_dst),
		.in_dat    (in_dat),
		.in_ready  (in_ready),
		.net_ready (net_ready),
		.out_valid (out_valid),
		.out_dst   (out_dst),
		.out_dat   (out_dat),
		.out_lane  (out_lane),
		.out_sub   (out_sub),
		.out_ready (out_ready)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	// lane a destination should leave on, tail lane when no node claims it
	function automatic logic [ns_net_pkg::LANE_W-1:0] lane_for(input ns_msg_pkg::dst_t dst);
		logic [ns_net_pkg::LANE_W-1:0] lane;
		lane = dst.f.node;
		if (dst.f.node >= ns_net_pkg::NODE_COUNT) begin
			lane = ns_net_pkg::NODE_COUNT;
		end
		return lane;
	endfunction

	task automatic check_dat(input ns_msg_pkg::data_t actual, input ns_msg_pkg::data_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t: out_dat is 0x%04h, expected 0x%04h",
				$time, actual, expected));
		end
	endtask

	task automatic check_dst(input ns_msg_pkg::dst_t actual, input ns_msg_pkg::dst_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t: out_dst is 0x%02h, expected 0x%02h",
				$time, actual.addr, expected.addr));
		end
	endtask

	task automatic check_lane(input logic [ns_net_pkg::LANE_W-1:0] actual,
			input logic [ns_net_pkg::LANE_W-1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t: out_lane is %0d, expected %0d",
				$time, actual, expected));
		end
	endtask

	task automatic check_sub(input logic [ns_msg_pkg::SUB_FIELD_W-1:0] actual,
			input logic [ns_msg_pkg::SUB_FIELD_W-1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t: out_sub is 0x%02h, expected 0x%02h",
				$time, actual, expected));
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string name);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR at %0t: %s is %b, expected %b",
				$time, name, actual, expected));
		end
	endtask

	task automatic push_expected(input ns_msg_pkg::dst_t dst, input ns_msg_pkg::data_t dat);
		logic [ns_net_pkg::LANE_W-1:0] lane;
		lane = lane_for(dst);
		exp_dst[lane].push_back(dst);
		exp_dat[lane].push_back(dat);
	endtask

	function automatic int pending_count();
		int total;
		total = 0;
		for (int l = 0; l < ns_net_pkg::LANE_COUNT; l++) begin
			total += exp_dst[l].size();
		end
		return total;
	endfunction

	// queue chosen by the delivered destination, lane tag checked against it
	task automatic take_output();
		logic [ns_net_pkg::LANE_W-1:0] lane;
		ns_msg_pkg::dst_t dst;
		ns_msg_pkg::data_t dat;
		lane = lane_for(out_dst);
		if (exp_dst[lane].size() == 0) begin
			abort_run($sformatf("unexpected message 0x%02h left on lane %0d at %0t",
				out_dst.addr, out_lane, $time));
		end else begin
			dst = exp_dst[lane].pop_front();
			dat = exp_dat[lane].pop_front();
			check_dst(out_dst, dst);
			check_lane(out_lane, lane_for(dst));
			check_sub(out_sub, dst.f.sub);
			check_dat(out_dat, dat);
		end
	endtask

	// mid-cycle sample, the transfer happens on the next rising edge
	always @(negedge i_clk) begin
		if (!reset && out_valid === 1'b1 && out_ready) begin
			take_output();
		end
	end

	// called 1 ns after a rising edge, returns 1 ns after the transfer edge
	task automatic send_msg(input ns_msg_pkg::dst_t dst, input ns_msg_pkg::data_t dat);
		in_valid = 1'b1;
		in_dst = dst;
		in_dat = dat;
		@(negedge i_clk);
		while (!in_ready) begin
			@(negedge i_clk);
		end
		push_expected(dst, dat);
		@(posedge i_clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (pending_count() != 0) begin
			@(posedge i_clk);
			#1;
		end
	endtask

	task automatic test_reset();
		int waited;
		@(negedge i_clk);
		while (reset) begin
			check_flag(in_ready, 1'b0, "in_ready");
			check_flag(out_valid, 1'b0, "out_valid");
			check_flag(net_ready, 1'b0, "net_ready");
			@(negedge i_clk);
		end
		waited = 0;
		while (net_ready !== 1'b1 && waited < 2) begin
			@(negedge i_clk);
			waited++;
		end
		if (net_ready !== 1'b1) begin
			abort_run("net_ready did not rise within 2 cycles after reset");
		end
		@(posedge i_clk);
		#1;
	endtask

	task automatic test_single_nodes();
		ns_msg_pkg::dst_t dst;
		for (int n = 0; n < ns_net_pkg::NODE_COUNT; n++) begin
			dst.f.node = n;
			dst.f.sub = $random(seed);
			send_msg(dst, $random(seed));
			wait_drain();
		end
	endtask

	// node value 3 names no node
	task automatic test_unroutable();
		ns_msg_pkg::dst_t dst;
		dst.f.node = 2'd3;
		dst.f.sub = $random(seed);
		send_msg(dst, $random(seed));
		wait_drain();
	endtask

	task automatic test_stream();
		out_ready = 1'b1;
		repeat (STREAM_COUNT) begin
			send_msg($random(seed), $random(seed));
		end
		wait_drain();
	endtask

	task automatic test_backpressure();
		int stall;
		int accepted;
		ns_msg_pkg::dst_t dst;
		ns_msg_pkg::data_t dat;
		out_ready = 1'b0;
		stall = 0;
		accepted = 0;
		dst = $random(seed);
		dat = $random(seed);
		in_valid = 1'b1;
		in_dst = dst;
		in_dat = dat;
		// offer until the network stops taking messages
		while (stall < STALL_CYCLES) begin
			@(negedge i_clk);
			if (in_ready) begin
				push_expected(dst, dat);
				accepted++;
				stall = 0;
				if (accepted > FILL_MAX) begin
					abort_run("in_ready kept accepting messages while out_ready was low");
				end
				@(posedge i_clk);
				#1;
				dst = $random(seed);
				dat = $random(seed);
				in_dst = dst;
				in_dat = dat;
			end else begin
				stall++;
			end
		end
		@(posedge i_clk);
		#1;
		in_valid = 1'b0;
		// drain with a randomly stalling host
		while (pending_count() != 0) begin
			out_ready = $random(seed);
			@(posedge i_clk);
			#1;
		end
		out_ready = 1'b1;
	endtask

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		abort_run("timeout, the network stopped delivering messages");
	end

	initial begin
		seed = 37200;
		in_valid = 1'b0;
		in_dst = '0;
		in_dat = '0;
		out_ready = 1'b1;
		test_reset();
		test_single_nodes();
		test_unroutable();
		test_stream();
		test_backpressure();
		// idle tail, any late extra output is caught by the monitor
		repeat (10) @(posedge i_clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/ns_msg_pkg.sv
verilog/ns_net_pkg.sv
verilog/ns_ingress.sv
verilog/nd_1to2.sv
verilog/ns_egress_arbiter.sv
verilog/ns_router_net.sv
dv/ns_clk_gen.sv
dv/ns_router_net_tb.sv

// ==== Makefile ====
# Verilator build and run for the router network testbench

VERILATOR ?= verilator
TOP       ?= ns_router_net_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit, so make fails too
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
